// File: hdl/isa_pkg.sv
package isa_pkg;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;

	////////////////////////////////////////
	// R-type function codes
	////////////////////////////////////////
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	// Same 32 bits, read as R-type or I-type
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////
	localparam int XLEN    = 32;
	localparam int REG_W   = 5;
	localparam int ALUOP_W = 4;
	localparam int IMM_W   = 16;

	////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////
	localparam logic [ALUOP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALUOP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALUOP_W-1:0] ALU_AND = 4'd2;
	localparam logic [ALUOP_W-1:0] ALU_OR  = 4'd3;
	localparam logic [ALUOP_W-1:0] ALU_XOR = 4'd4;
	localparam logic [ALUOP_W-1:0] ALU_SLT = 4'd5;
	// Immediate moved into the upper half
	localparam logic [ALUOP_W-1:0] ALU_LUI = 4'd6;

endpackage

// File: hdl/id_decoder.sv
`timescale 1ns/100ps

module id_decoder (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ins_req,
	input  isa_pkg::instr_u               ins_data,
	output logic                          ins_ack,
	output logic [pipe_pkg::REG_W-1:0]    rs_addr,
	output logic [pipe_pkg::REG_W-1:0]    rt_addr,
	input  logic [pipe_pkg::XLEN-1:0]     rs_data,
	input  logic [pipe_pkg::XLEN-1:0]     rt_data,
	input  logic                          exe_valid,
	input  logic [pipe_pkg::REG_W-1:0]    exe_dreg,
	input  logic                          exe_we,
	output logic                          exe_load,
	output logic                          exe_clear,
	output logic [pipe_pkg::ALUOP_W-1:0]  id_aluop,
	output logic [pipe_pkg::XLEN-1:0]     id_rega,
	output logic [pipe_pkg::XLEN-1:0]     id_regb,
	output logic [pipe_pkg::IMM_W-1:0]    id_imme,
	output logic                          id_srcb,
	output logic                          id_sign,
	output logic [pipe_pkg::REG_W-1:0]    id_dreg,
	output logic                          id_we,
	output logic                          res_req,
	input  logic                          res_ack
);
	import isa_pkg::*;
	import pipe_pkg::*;

	instr_u buf_word;
	logic   buf_valid;
	logic   ins_take;
	logic   known;
	logic   uses_rs;
	logic   uses_rt;
	logic   hazard;

	////////////////////////////////////////
	// Decode of the buffered word
	////////////////////////////////////////
	assign rs_addr = buf_word.r.rs;
	assign rt_addr = buf_word.r.rt;
	assign id_rega = rs_data;
	assign id_regb = rt_data;
	assign id_imme = buf_word.i.imm;
	// Unknown encodings still retire without a write
	assign id_we   = known;

	always_comb begin
		id_aluop = ALU_ADD;
		id_srcb  = 1'b0;
		id_sign  = 1'b0;
		id_dreg  = buf_word.r.rd;
		known    = 1'b0;
		uses_rs  = 1'b0;
		uses_rt  = 1'b0;
		case (buf_word.r.opcode)
			OP_RTYPE: begin
				known   = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				case (buf_word.r.funct)
					FN_ADD:  id_aluop = ALU_ADD;
					FN_SUB:  id_aluop = ALU_SUB;
					FN_AND:  id_aluop = ALU_AND;
					FN_OR:   id_aluop = ALU_OR;
					FN_XOR:  id_aluop = ALU_XOR;
					FN_SLT:  id_aluop = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			OP_ADDI: begin
				known    = 1'b1;
				uses_rs  = 1'b1;
				id_srcb  = 1'b1;
				id_sign  = 1'b1;
				id_dreg  = buf_word.i.rt;
			end
			OP_ORI: begin
				known    = 1'b1;
				uses_rs  = 1'b1;
				id_aluop = ALU_OR;
				id_srcb  = 1'b1;
				id_dreg  = buf_word.i.rt;
			end
			OP_LUI: begin
				known    = 1'b1;
				id_aluop = ALU_LUI;
				id_srcb  = 1'b1;
				id_dreg  = buf_word.i.rt;
			end
			default: known = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// Hazard and ID/EX control
	////////////////////////////////////////
	// RAW against the ID/EX item that writes back only at retire
	assign hazard = exe_valid && exe_we && (exe_dreg != '0) &&
		((known && uses_rs && exe_dreg == rs_addr) ||
		 (known && uses_rt && exe_dreg == rt_addr));

	// Retire on the edge where res_ack is seen with res_req up
	assign exe_clear = res_req && res_ack;
	assign exe_load  = buf_valid && (!exe_valid || exe_clear) && !hazard;

	// Buffer accepts a word when empty or emptying this edge
	assign ins_take = ins_req && !ins_ack && (!buf_valid || exe_load);

	////////////////////////////////////////
	// Handshake state
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			ins_ack   <= 1'b0;
			buf_valid <= 1'b0;
			res_req   <= 1'b0;
		end else begin
			if (ins_take)
				ins_ack <= 1'b1;
			else if (!ins_req)
				ins_ack <= 1'b0;

			if (ins_take)
				buf_valid <= 1'b1;
			else if (exe_load)
				buf_valid <= 1'b0;

			// Next result waits for res_ack to return low
			if (exe_clear)
				res_req <= 1'b0;
			else if (exe_valid && !res_ack)
				res_req <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ins_take)
			buf_word <= ins_data;
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ins_ack) |-> $past(ins_req));

	a_res_req_held: assert property (@(posedge clk) disable iff (rst)
		res_req && !res_ack |=> res_req);

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [pipe_pkg::REG_W-1:0] rs_addr,
	input  logic [pipe_pkg::REG_W-1:0] rt_addr,
	output logic [pipe_pkg::XLEN-1:0]  rs_data,
	output logic [pipe_pkg::XLEN-1:0]  rt_data,
	input  logic                       wr_en,
	input  logic [pipe_pkg::REG_W-1:0] wr_addr,
	input  logic [pipe_pkg::XLEN-1:0]  wr_data
);
	import pipe_pkg::*;

	localparam int NREGS = 2**REG_W;

	logic [XLEN-1:0] regs [NREGS];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	// r0 is hardwired to zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: hdl/id_exe_reg.sv
`timescale 1ns/100ps

module id_exe_reg (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          load,
	input  logic                          clear,
	input  logic [pipe_pkg::ALUOP_W-1:0]  aluop,
	input  logic [pipe_pkg::XLEN-1:0]     rega,
	input  logic [pipe_pkg::XLEN-1:0]     regb,
	input  logic [pipe_pkg::IMM_W-1:0]    imme,
	input  logic                          srcb,
	input  logic                          sign,
	input  logic [pipe_pkg::REG_W-1:0]    dreg,
	input  logic                          we,
	output logic [pipe_pkg::ALUOP_W-1:0]  exe_aluop,
	output logic [pipe_pkg::XLEN-1:0]     exe_rega,
	output logic [pipe_pkg::XLEN-1:0]     exe_regb,
	output logic [pipe_pkg::IMM_W-1:0]    exe_imme,
	output logic                          exe_srcb,
	output logic                          exe_sign,
	output logic [pipe_pkg::REG_W-1:0]    exe_dreg,
	output logic                          exe_we,
	output logic                          exe_valid
);

	////////////////////////////////////////
	// Valid and write enable
	////////////////////////////////////////
	// Load wins when it meets clear on a retire edge
	always_ff @(posedge clk) begin
		if (rst) begin
			exe_valid <= 1'b0;
			exe_we    <= 1'b0;
		end else if (load) begin
			exe_valid <= 1'b1;
			exe_we    <= we;
		end else if (clear) begin
			exe_valid <= 1'b0;
			exe_we    <= 1'b0;
		end
	end

	// Operands and controls for execute
	always_ff @(posedge clk) begin
		if (load) begin
			exe_aluop <= aluop;
			exe_rega  <= rega;
			exe_regb  <= regb;
			exe_imme  <= imme;
			exe_srcb  <= srcb;
			exe_sign  <= sign;
			exe_dreg  <= dreg;
		end
	end

	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		load |-> (!exe_valid || clear));

endmodule

// File: hdl/exe_alu.sv
`timescale 1ns/100ps

module exe_alu (
	input  logic [pipe_pkg::ALUOP_W-1:0] exe_aluop,
	input  logic [pipe_pkg::XLEN-1:0]    exe_rega,
	input  logic [pipe_pkg::XLEN-1:0]    exe_regb,
	input  logic [pipe_pkg::IMM_W-1:0]   exe_imme,
	input  logic                         exe_srcb,
	input  logic                         exe_sign,
	output logic [pipe_pkg::XLEN-1:0]    result
);
	import pipe_pkg::*;

	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] opb;

	////////////////////////////////////////
	// Operand B
	////////////////////////////////////////
	always_comb begin
		if (exe_sign)
			imm_ext = {{(XLEN-IMM_W){exe_imme[IMM_W-1]}}, exe_imme};
		else
			imm_ext = {{(XLEN-IMM_W){1'b0}}, exe_imme};
	end

	assign opb = exe_srcb ? imm_ext : exe_regb;

	////////////////////////////////////////
	// Function unit
	////////////////////////////////////////
	always_comb begin
		case (exe_aluop)
			ALU_ADD: result = exe_rega + opb;
			ALU_SUB: result = exe_rega - opb;
			ALU_AND: result = exe_rega & opb;
			ALU_OR:  result = exe_rega | opb;
			ALU_XOR: result = exe_rega ^ opb;
			// Signed compare giving 0 or 1
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(exe_rega) < $signed(opb)};
			ALU_LUI: result = {exe_imme, {(XLEN-IMM_W){1'b0}}};
			default: result = '0;
		endcase
	end

endmodule

// File: hdl/core_slice.sv
`timescale 1ns/100ps

module core_slice (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ins_req,
	input  isa_pkg::instr_u            ins_data,
	output logic                       ins_ack,
	output logic                       res_req,
	input  logic                       res_ack,
	output logic [pipe_pkg::XLEN-1:0]  res_data,
	output logic [pipe_pkg::REG_W-1:0] res_dreg,
	output logic                       res_we
);
	import pipe_pkg::*;

	logic [REG_W-1:0]   rs_addr;
	logic [REG_W-1:0]   rt_addr;
	logic [XLEN-1:0]    rs_data;
	logic [XLEN-1:0]    rt_data;
	logic               exe_load;
	logic               exe_clear;
	logic               exe_valid;
	logic               wr_en;

	// Decode side of ID/EX
	logic [ALUOP_W-1:0] id_aluop;
	logic [XLEN-1:0]    id_rega;
	logic [XLEN-1:0]    id_regb;
	logic [IMM_W-1:0]   id_imme;
	logic               id_srcb;
	logic               id_sign;
	logic [REG_W-1:0]   id_dreg;
	logic               id_we;

	// Execute side of ID/EX
	logic [ALUOP_W-1:0] exe_aluop;
	logic [XLEN-1:0]    exe_rega;
	logic [XLEN-1:0]    exe_regb;
	logic [IMM_W-1:0]   exe_imme;
	logic               exe_srcb;
	logic               exe_sign;
	logic [REG_W-1:0]   exe_dreg;
	logic               exe_we;

	assign res_dreg = exe_dreg;
	assign res_we   = exe_we;
	// Writeback happens at retire
	assign wr_en    = res_req && res_ack && exe_we;

	id_decoder u_id_decoder (
		.clk       (clk),
		.rst       (rst),
		.ins_req   (ins_req),
		.ins_data  (ins_data),
		.ins_ack   (ins_ack),
		.rs_addr   (rs_addr),
		.rt_addr   (rt_addr),
		.rs_data   (rs_data),
		.rt_data   (rt_data),
		.exe_valid (exe_valid),
		.exe_dreg  (exe_dreg),
		.exe_we    (exe_we),
		.exe_load  (exe_load),
		.exe_clear (exe_clear),
		.id_aluop  (id_aluop),
		.id_rega   (id_rega),
		.id_regb   (id_regb),
		.id_imme   (id_imme),
		.id_srcb   (id_srcb),
		.id_sign   (id_sign),
		.id_dreg   (id_dreg),
		.id_we     (id_we),
		.res_req   (res_req),
		.res_ack   (res_ack)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (wr_en),
		.wr_addr (exe_dreg),
		.wr_data (res_data)
	);

	id_exe_reg u_id_exe_reg (
		.clk       (clk),
		.rst       (rst),
		.load      (exe_load),
		.clear     (exe_clear),
		.aluop     (id_aluop),
		.rega      (id_rega),
		.regb      (id_regb),
		.imme      (id_imme),
		.srcb      (id_srcb),
		.sign      (id_sign),
		.dreg      (id_dreg),
		.we        (id_we),
		.exe_aluop (exe_aluop),
		.exe_rega  (exe_rega),
		.exe_regb  (exe_regb),
		.exe_imme  (exe_imme),
		.exe_srcb  (exe_srcb),
		.exe_sign  (exe_sign),
		.exe_dreg  (exe_dreg),
		.exe_we    (exe_we),
		.exe_valid (exe_valid)
	);

	exe_alu u_exe_alu (
		.exe_aluop (exe_aluop),
		.exe_rega  (exe_rega),
		.exe_regb  (exe_regb),
		.exe_imme  (exe_imme),
		.exe_srcb  (exe_srcb),
		.exe_sign  (exe_sign),
		.result    (res_data)
	);

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held over the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: testbench/tb_core_slice.sv
`timescale 1ns/100ps

module tb_core_slice;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int N_RANDOM   = 40;

	logic               clk;
	logic               rst;
	logic               ins_req;
	instr_u             ins_data;
	logic               ins_ack;
	logic               res_req;
	logic               res_ack;
	logic [XLEN-1:0]    res_data;
	logic [REG_W-1:0]   res_dreg;
	logic               res_we;

	instr_u             program_q[$];
	instr_u             pending_q[$];
	instr_u             retire_word;
	logic [XLEN-1:0]    model_regs [32];
	logic [XLEN-1:0]    exp_data;
	logic [REG_W-1:0]   exp_dreg;
	logic               has_head;
	logic               retire_due;
	int                 retired;

	tb_clock u_tb_clock (
		.clk (clk),
		.rst (rst)
	);

	core_slice u_core_slice (
		.clk      (clk),
		.rst      (rst),
		.ins_req  (ins_req),
		.ins_data (ins_data),
		.ins_ack  (ins_ack),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data),
		.res_dreg (res_dreg),
		.res_we   (res_we)
	);

	task automatic stop_with_failure(input string msg);
		$display("SOME TESTS FAILED");
		$display("%s", msg);
		$fatal(1, "stopped at first error");
	endtask

	////////////////////////////////////////
	// Instruction words
	////////////////////////////////////////
	function automatic instr_u make_rtype(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		instr_u w;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.shamt  = '0;
		w.r.funct  = funct;
		return w;
	endfunction

	function automatic instr_u make_itype(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	function automatic instr_u random_instr();
		int unsigned sel;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		sel = $urandom_range(0, 8);
		rs  = 5'($urandom_range(0, 15));
		rt  = 5'($urandom_range(0, 15));
		rd  = 5'($urandom_range(0, 15));
		imm = 16'($urandom());
		case (sel)
			0: return make_rtype(FN_ADD, rd, rs, rt);
			1: return make_rtype(FN_SUB, rd, rs, rt);
			2: return make_rtype(FN_AND, rd, rs, rt);
			3: return make_rtype(FN_OR, rd, rs, rt);
			4: return make_rtype(FN_XOR, rd, rs, rt);
			5: return make_rtype(FN_SLT, rd, rs, rt);
			6: return make_itype(OP_ADDI, rd, rs, imm);
			7: return make_itype(OP_ORI, rd, rs, imm);
			default: return make_itype(OP_LUI, rd, rs, imm);
		endcase
	endfunction

	function automatic void build_program();
		// Zero operands, then immediates, then a write to r0
		program_q.push_back(make_rtype(FN_ADD, 5'd1, 5'd2, 5'd3));
		program_q.push_back(make_itype(OP_ADDI, 5'd1, 5'd0, 16'hfffb));
		program_q.push_back(make_itype(OP_ORI, 5'd2, 5'd0, 16'h8001));
		program_q.push_back(make_itype(OP_LUI, 5'd3, 5'd0, 16'h1234));
		program_q.push_back(make_itype(OP_ADDI, 5'd0, 5'd3, 16'h0007));
		program_q.push_back(make_rtype(FN_ADD, 5'd4, 5'd0, 5'd3));
		program_q.push_back(make_rtype(FN_ADD, 5'd5, 5'd1, 5'd2));
		program_q.push_back(make_rtype(FN_SUB, 5'd6, 5'd1, 5'd2));
		program_q.push_back(make_rtype(FN_AND, 5'd7, 5'd2, 5'd3));
		program_q.push_back(make_rtype(FN_OR, 5'd8, 5'd1, 5'd3));
		program_q.push_back(make_rtype(FN_XOR, 5'd9, 5'd1, 5'd2));
		program_q.push_back(make_rtype(FN_SLT, 5'd10, 5'd1, 5'd2));
		program_q.push_back(make_rtype(FN_SLT, 5'd11, 5'd2, 5'd1));
		// Dependent chain where each needs the one before
		program_q.push_back(make_itype(OP_ADDI, 5'd12, 5'd12, 16'h0003));
		program_q.push_back(make_itype(OP_ADDI, 5'd12, 5'd12, 16'h0003));
		program_q.push_back(make_rtype(FN_ADD, 5'd13, 5'd12, 5'd12));
		program_q.push_back(make_rtype(FN_SUB, 5'd12, 5'd13, 5'd12));
		program_q.push_back(make_rtype(FN_XOR, 5'd13, 5'd13, 5'd12));
		program_q.push_back(make_rtype(FN_SLT, 5'd14, 5'd12, 5'd13));
		for (int k = 0; k < N_RANDOM; k++)
			program_q.push_back(random_instr());
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic logic [XLEN-1:0] expected_value(input instr_u w);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		a = model_regs[w.r.rs];
		b = model_regs[w.r.rt];
		case (w.r.opcode)
			OP_RTYPE: begin
				case (w.r.funct)
					FN_ADD:  return a + b;
					FN_SUB:  return a - b;
					FN_AND:  return a & b;
					FN_OR:   return a | b;
					FN_XOR:  return a ^ b;
					FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: return '0;
				endcase
			end
			OP_ADDI: return a + {{16{w.i.imm[15]}}, w.i.imm};
			OP_ORI:  return a | {16'h0000, w.i.imm};
			OP_LUI:  return {w.i.imm, 16'h0000};
			default: return '0;
		endcase
	endfunction

	function automatic logic [REG_W-1:0] expected_dest(input instr_u w);
		return (w.r.opcode == OP_RTYPE) ? w.r.rd : w.i.rt;
	endfunction

	// Retire seen at one edge is applied at the next falling edge
	always @(negedge clk) begin
		if (rst) begin
			for (int k = 0; k < 32; k++)
				model_regs[k] = '0;
			retire_due = 1'b0;
			retired    = 0;
		end else begin
			if (retire_due) begin
				retire_word = pending_q.pop_front();
				if (expected_dest(retire_word) != '0)
					model_regs[expected_dest(retire_word)] = expected_value(retire_word);
				retired++;
			end
			retire_due = res_req && res_ack;
		end
		has_head = (pending_q.size() > 0);
		if (has_head) begin
			exp_data = expected_value(pending_q[0]);
			exp_dreg = expected_dest(pending_q[0]);
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	a_reset_idle: assert property (@(posedge clk) rst |=> (!ins_ack && !res_req))
		else stop_with_failure("ins_ack or res_req was high right after reset");

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ins_ack) |-> $past(ins_req))
		else stop_with_failure("ins_ack rose without a pending ins_req");

	a_req_until_ack: assert property (@(posedge clk) disable iff (rst)
		res_req && !res_ack |=> res_req)
		else stop_with_failure("res_req fell before res_ack was seen");

	a_req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
		$rose(res_req) |-> !$past(res_ack))
		else stop_with_failure("res_req rose while res_ack was still high");

	a_result_expected: assert property (@(posedge clk) disable iff (rst)
		res_req |-> has_head)
		else stop_with_failure("result offered with no instruction outstanding");

	a_data_match: assert property (@(posedge clk) disable iff (rst)
		res_req |-> res_data == exp_data)
		else stop_with_failure($sformatf("mismatch at %0t: res_data expected %h actual %h",
			$time, $sampled(exp_data), $sampled(res_data)));

	a_dreg_match: assert property (@(posedge clk) disable iff (rst)
		res_req |-> res_dreg == exp_dreg)
		else stop_with_failure($sformatf("mismatch at %0t: res_dreg expected %0d actual %0d",
			$time, $sampled(exp_dreg), $sampled(res_dreg)));

	a_we_match: assert property (@(posedge clk) disable iff (rst)
		res_req |-> res_we)
		else stop_with_failure($sformatf("mismatch at %0t: res_we expected 1 actual %0b",
			$time, $sampled(res_we)));

	a_result_stable: assert property (@(posedge clk) disable iff (rst)
		res_req && !res_ack |=> $stable(res_data) && $stable(res_dreg))
		else stop_with_failure("res_data or res_dreg changed while res_req was high");

	////////////////////////////////////////
	// Handshake drivers
	////////////////////////////////////////
	task automatic wait_ins_ack(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (ins_ack != level) begin
			n++;
			if (n > WAIT_LIMIT)
				stop_with_failure($sformatf("timeout while waiting for ins_ack to be %0b", level));
			else
				@(negedge clk);
		end
	endtask

	task automatic wait_res_req(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (res_req != level) begin
			n++;
			if (n > WAIT_LIMIT)
				stop_with_failure($sformatf("timeout while waiting for res_req to be %0b", level));
			else
				@(negedge clk);
		end
	endtask

	task automatic wait_reset_done();
		int n;
		n = 0;
		@(negedge clk);
		while (rst) begin
			n++;
			if (n > WAIT_LIMIT)
				stop_with_failure("timeout while waiting for reset to end");
			else
				@(negedge clk);
		end
	endtask

	task automatic wait_all_retired();
		int n;
		n = 0;
		@(negedge clk);
		while (retired < program_q.size()) begin
			n++;
			if (n > WAIT_LIMIT)
				stop_with_failure("timeout while waiting for the last results to retire");
			else
				@(negedge clk);
		end
	endtask

	task automatic run_source();
		foreach (program_q[k]) begin
			wait_ins_ack(1'b0);
			@(posedge clk);
			ins_data <= program_q[k];
			ins_req  <= 1'b1;
			pending_q.push_back(program_q[k]);
			wait_ins_ack(1'b1);
			@(posedge clk);
			ins_req <= 1'b0;
		end
	endtask

	task automatic run_sink();
		int unsigned delay;
		for (int k = 0; k < program_q.size(); k++) begin
			wait_res_req(1'b1);
			delay = $urandom_range(0, 3);
			repeat (delay) @(negedge clk);
			@(posedge clk);
			res_ack <= 1'b1;
			wait_res_req(1'b0);
			@(posedge clk);
			res_ack <= 1'b0;
		end
	endtask

	initial begin
		ins_req  = 1'b0;
		ins_data = '0;
		res_ack  = 1'b0;
		void'($urandom(74));
		build_program();
		wait_reset_done();
		fork
			run_source();
			run_sink();
		join
		wait_all_retired();
		// Idle a little so a spurious extra result would be caught
		repeat (4) @(negedge clk);
		if (retired == program_q.size() && pending_q.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_with_failure("retired results do not match the issued program");
		end
	end

endmodule

// File: list.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/id_decoder.sv
hdl/reg_file.sv
hdl/id_exe_reg.sv
hdl/exe_alu.sv
hdl/core_slice.sv
testbench/tb_clock.sv
testbench/tb_core_slice.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_core_slice
FILELIST := list.f
OBJDIR   := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
